// ==== Bender.yml ====
package:
  name: dcache_subsys

sources:
  # package first, then the design bottom up
  - files:
      - source/dcache_pkg.sv
      - source/dcache_way_if.sv
      - source/sdp_ram.sv
      - source/dcache_way.sv
      - source/dcache_ctrl.sv
      - source/dcache_top.sv

  # simulation only
  - target: test
    files:
      - testbench/dcache_mem_model.sv
      - testbench/tb_dcache_top.sv

// ==== dcache_subsys.f ====
source/dcache_pkg.sv
source/dcache_way_if.sv
source/sdp_ram.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/dcache_mem_model.sv
testbench/tb_dcache_top.sv

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int NUM_SETS = 128
) (
    input  logic        clk,
    input  logic        reset,
    // cpu side
    input  logic        req_i,
    input  mem_op_e     op_i,
    input  logic        uncached_i,
    input  word_t       addr_i,
    input  word_t       wdata_i,
    input  strb_t       wstrb_i,
    output logic        ready_o,
    output logic        data_ok_o,
    output word_t       rdata_o,
    // line port
    output logic        rd_req_o,
    output word_t       rd_addr_o,
    input  logic        ret_valid_i,
    input  line_t       ret_data_i,
    output logic        wr_req_o,
    output word_t       wr_addr_o,
    output line_t       wr_data_o,
    // uncached port
    output logic        unc_ren_o,
    output logic        unc_wen_o,
    output word_t       unc_addr_o,
    output word_t       unc_wdata_o,
    output strb_t       unc_strb_o,
    input  logic        unc_rvalid_i,
    input  word_t       unc_rdata_i,
    input  logic        unc_bvalid_i,
    // ways
    dcache_way_if.ctrl  way0,
    dcache_way_if.ctrl  way1
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - IDX_W - OFFSET_BITS;

    cache_state_e state_q, state_d;
    logic         entry_q;   // first cycle in a state

    // held request
    mem_op_e      req_op_q;
    word_t        req_addr_q;
    word_t        req_wdata_q;
    strb_t        req_wstrb_q;
    logic         victim_q;

    logic [1:0][NUM_SETS-1:0] valid_q;
    logic [1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]      lru_q;     // way used last

    logic [IDX_W-1:0] req_idx;
    logic [TAG_W-1:0] req_tag;
    logic [2:0]       word_sel;
    logic             accept, lookup, hit0, hit1, hit_any;
    logic             store_hit, refill_done, unc_done, victim;
    line_t            hit_line, merge_base, fill_line;
    word_t            merged_word;
    strb_t [LINE_WORDS-1:0] bank_en;

    assign req_idx  = req_addr_q[IDX_W+OFFSET_BITS-1:OFFSET_BITS];
    assign req_tag  = req_addr_q[31:IDX_W+OFFSET_BITS];
    assign word_sel = req_addr_q[4:2];

    assign accept = req_i && ready_o;
    assign lookup = (state_q == ST_LOOKUP);

    assign hit0    = way0.rd_valid && valid_q[0][req_idx] && (way0.rd_tag == req_tag);
    assign hit1    = way1.rd_valid && valid_q[1][req_idx] && (way1.rd_tag == req_tag);
    assign hit_any = hit0 || hit1;
    assign hit_line = hit1 ? way1.rd_line : way0.rd_line;

    assign store_hit   = lookup && hit_any && (req_op_q == OP_STORE);
    assign refill_done = (state_q == ST_REFILL) && ret_valid_i;
    assign unc_done    = (state_q == ST_UNCACHE) &&
                         ((req_op_q == OP_LOAD) ? unc_rvalid_i : unc_bvalid_i);
    assign victim      = ~lru_q[req_idx];

    // load hits keep the pipe open
    assign ready_o = (state_q == ST_IDLE) ||
                     (lookup && hit_any && (req_op_q == OP_LOAD));

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (accept) state_d = uncached_i ? ST_UNCACHE : ST_LOOKUP;
            end
            ST_LOOKUP: begin
                if (hit_any) begin
                    if (accept) state_d = uncached_i ? ST_UNCACHE : ST_LOOKUP;
                    else state_d = ST_IDLE;
                end else begin
                    state_d = dirty_q[victim][req_idx] ? ST_WRITEBACK : ST_REFILL;
                end
            end
            ST_WRITEBACK: state_d = ST_REFILL;
            ST_REFILL: begin
                if (ret_valid_i) state_d = ST_IDLE;
            end
            ST_UNCACHE: begin
                if (unc_done) state_d = ST_IDLE;
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= ST_IDLE;
            entry_q <= 1'b0;
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            entry_q <= (state_d != state_q);
            if (lookup && hit_any) begin
                lru_q[req_idx] <= hit1;
                if (req_op_q == OP_STORE) dirty_q[hit1][req_idx] <= 1'b1;
            end
            if (refill_done) begin
                valid_q[victim_q][req_idx] <= 1'b1;
                dirty_q[victim_q][req_idx] <= (req_op_q == OP_STORE);
                lru_q[req_idx]             <= victim_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op_q    <= op_i;
            req_addr_q  <= addr_i;
            req_wdata_q <= wdata_i;
            req_wstrb_q <= wstrb_i;
        end
        if (lookup && !hit_any) victim_q <= victim;
    end

    // store bytes merged into the hit line or the returned line
    always_comb begin
        merge_base  = (state_q == ST_REFILL) ? ret_data_i : hit_line;
        merged_word = merge_base[word_sel*32 +: 32];
        for (int b = 0; b < 4; b++) begin
            if (req_op_q == OP_STORE && req_wstrb_q[b]) begin
                merged_word[b*8 +: 8] = req_wdata_q[b*8 +: 8];
            end
        end
        fill_line = merge_base;
        fill_line[word_sel*32 +: 32] = merged_word;
    end

    always_comb begin
        bank_en = '0;
        if (refill_done) bank_en = '1;
        else if (store_hit) bank_en[word_sel] = req_wstrb_q;
    end

    // ram side, read index follows the incoming request when accepting
    assign way0.rd_index   = accept ? addr_i[IDX_W+OFFSET_BITS-1:OFFSET_BITS] : req_idx;
    assign way1.rd_index   = way0.rd_index;
    assign way0.wr_index   = req_idx;
    assign way1.wr_index   = req_idx;
    assign way0.wr_line    = fill_line;
    assign way1.wr_line    = fill_line;
    assign way0.wr_tag     = req_tag;
    assign way1.wr_tag     = req_tag;
    assign way0.wr_tagv    = refill_done && !victim_q;
    assign way1.wr_tagv    = refill_done && victim_q;
    assign way0.wr_bank_en = ((store_hit && !hit1) || way0.wr_tagv) ? bank_en : '0;
    assign way1.wr_bank_en = ((store_hit && hit1) || way1.wr_tagv) ? bank_en : '0;

    always_comb begin
        rdata_o = hit_line[word_sel*32 +: 32];
        case (state_q)
            ST_REFILL:  rdata_o = fill_line[word_sel*32 +: 32];
            ST_UNCACHE: rdata_o = unc_rdata_i;
            default: ;
        endcase
    end

    assign data_ok_o = (lookup && hit_any) || refill_done || unc_done;

    // line port
    assign rd_req_o  = (state_q == ST_REFILL) && entry_q;
    assign rd_addr_o = {req_addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign wr_req_o  = (state_q == ST_WRITEBACK);
    assign wr_addr_o = {(victim_q ? way1.rd_tag : way0.rd_tag), req_idx, {OFFSET_BITS{1'b0}}};
    assign wr_data_o = victim_q ? way1.rd_line : way0.rd_line;

    // uncached port
    assign unc_ren_o   = (state_q == ST_UNCACHE) && entry_q && (req_op_q == OP_LOAD);
    assign unc_wen_o   = (state_q == ST_UNCACHE) && entry_q && (req_op_q == OP_STORE);
    assign unc_addr_o  = req_addr_q;
    assign unc_wdata_o = req_wdata_q;
    assign unc_strb_o  = req_wstrb_q;

    a_one_way_hit: assert property (
        @(posedge clk) disable iff (reset) lookup |-> !(hit0 && hit1)
    ) else $error("line resident in both ways");

    a_line_req_excl: assert property (
        @(posedge clk) disable iff (reset) !(rd_req_o && wr_req_o)
    ) else $error("read and write line requests together");

    a_no_ok_idle: assert property (
        @(posedge clk) disable iff (reset) (state_q == ST_IDLE) |-> !data_ok_o
    ) else $error("data_ok while idle");

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    // line geometry
    localparam int LINE_WORDS  = 8;
    localparam int OFFSET_BITS = 5;   // word select is addr[4:2]

    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;

    // word 0 sits in the lowest 32 bits
    typedef logic [LINE_WORDS*32-1:0] line_t;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } mem_op_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,   // dirty victim goes out as one line
        ST_REFILL,
        ST_UNCACHE
    } cache_state_e;

endpackage

// ==== source/dcache_top.sv ====
`timescale 1ns/10ps

module dcache_top import dcache_pkg::*; #(
    parameter int NUM_SETS = 128
) (
    input  logic    clk,
    input  logic    reset,
    // cpu
    input  logic    req_i,
    input  mem_op_e op_i,
    input  logic    uncached_i,
    input  word_t   addr_i,
    input  word_t   wdata_i,
    input  strb_t   wstrb_i,
    output logic    ready_o,
    output logic    data_ok_o,
    output word_t   rdata_o,
    // line port
    output logic    rd_req_o,
    output word_t   rd_addr_o,
    input  logic    ret_valid_i,
    input  line_t   ret_data_i,
    output logic    wr_req_o,
    output word_t   wr_addr_o,
    output line_t   wr_data_o,
    // uncached port
    output logic    unc_ren_o,
    output logic    unc_wen_o,
    output word_t   unc_addr_o,
    output word_t   unc_wdata_o,
    output strb_t   unc_strb_o,
    input  logic    unc_rvalid_i,
    input  word_t   unc_rdata_i,
    input  logic    unc_bvalid_i
);

    dcache_way_if #(.NUM_SETS(NUM_SETS)) way0_if ();
    dcache_way_if #(.NUM_SETS(NUM_SETS)) way1_if ();

    dcache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .req_i        (req_i),
        .op_i         (op_i),
        .uncached_i   (uncached_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .wstrb_i      (wstrb_i),
        .ready_o      (ready_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .wr_req_o     (wr_req_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o),
        .unc_ren_o    (unc_ren_o),
        .unc_wen_o    (unc_wen_o),
        .unc_addr_o   (unc_addr_o),
        .unc_wdata_o  (unc_wdata_o),
        .unc_strb_o   (unc_strb_o),
        .unc_rvalid_i (unc_rvalid_i),
        .unc_rdata_i  (unc_rdata_i),
        .unc_bvalid_i (unc_bvalid_i),
        .way0         (way0_if.ctrl),
        .way1         (way1_if.ctrl)
    );

    dcache_way #(.NUM_SETS(NUM_SETS)) u_way0 (
        .clk  (clk),
        .port (way0_if.way)
    );

    dcache_way #(.NUM_SETS(NUM_SETS)) u_way1 (
        .clk  (clk),
        .port (way1_if.way)
    );

endmodule

// ==== source/dcache_way.sv ====
`timescale 1ns/10ps

module dcache_way import dcache_pkg::*; #(
    parameter int NUM_SETS = 128
) (
    input logic       clk,
    dcache_way_if.way port
);

    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int TAG_W  = 32 - IDX_W - OFFSET_BITS;
    localparam int TAGV_W = TAG_W + 1;

    logic [TAGV_W-1:0] tagv_rd;

    // data banks, one per word position
    for (genvar b = 0; b < LINE_WORDS; b++) begin : g_bank
        sdp_ram #(
            .DEPTH (NUM_SETS),
            .WIDTH (32)
        ) u_bank (
            .clk       (clk),
            .wr_en_i   (port.wr_bank_en[b]),
            .wr_addr_i (port.wr_index),
            .wr_data_i (port.wr_line[b*32 +: 32]),
            .rd_addr_i (port.rd_index),
            .rd_data_o (port.rd_line[b*32 +: 32])
        );
    end

    // tag plus valid, valid in the top bit
    sdp_ram #(
        .DEPTH (NUM_SETS),
        .WIDTH (TAGV_W)
    ) u_tagv (
        .clk       (clk),
        .wr_en_i   (port.wr_tagv),
        .wr_addr_i (port.wr_index),
        .wr_data_i ({1'b1, port.wr_tag}),
        .rd_addr_i (port.rd_index),
        .rd_data_o (tagv_rd)
    );

    assign port.rd_valid = tagv_rd[TAG_W];
    assign port.rd_tag   = tagv_rd[TAG_W-1:0];

    // a new tag only comes with a full line
    a_tagv_full_line: assert property (
        @(posedge clk) port.wr_tagv |-> (&port.wr_bank_en)
    ) else $error("tag write without a full line write");

endmodule

// ==== source/dcache_way_if.sv ====
`timescale 1ns/10ps

interface dcache_way_if import dcache_pkg::*; #(
    parameter int NUM_SETS = 128
) ();

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - IDX_W - OFFSET_BITS;

    logic [IDX_W-1:0]            rd_index;
    logic [IDX_W-1:0]            wr_index;
    strb_t [LINE_WORDS-1:0]      wr_bank_en;   // byte enables per bank
    line_t                       wr_line;
    logic                        wr_tagv;
    logic [TAG_W-1:0]            wr_tag;
    line_t                       rd_line;      // one cycle after rd_index
    logic [TAG_W-1:0]            rd_tag;
    logic                        rd_valid;

    modport ctrl (
        output rd_index, wr_index, wr_bank_en, wr_line, wr_tagv, wr_tag,
        input  rd_line, rd_tag, rd_valid
    );

    modport way (
        input  rd_index, wr_index, wr_bank_en, wr_line, wr_tagv, wr_tag,
        output rd_line, rd_tag, rd_valid
    );

endinterface

// ==== source/sdp_ram.sv ====
`timescale 1ns/10ps

module sdp_ram #(
    parameter int DEPTH = 128,
    parameter int WIDTH = 32
) (
    input  logic                                      clk,
    input  logic [((WIDTH % 8 == 0) ? WIDTH / 8 : 1)-1:0] wr_en_i,
    input  logic [$clog2(DEPTH)-1:0]                  wr_addr_i,
    input  logic [WIDTH-1:0]                          wr_data_i,
    input  logic [$clog2(DEPTH)-1:0]                  rd_addr_i,
    output logic [WIDTH-1:0]                          rd_data_o
);

    // one lane per byte, or a single lane for odd widths
    localparam int LANES  = (WIDTH % 8 == 0) ? WIDTH / 8 : 1;
    localparam int LANE_W = WIDTH / LANES;

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (wr_en_i[i]) begin
                mem[wr_addr_i][i*LANE_W +: LANE_W] <= wr_data_i[i*LANE_W +: LANE_W];
            end
        end
    end

    // read before write on a collision
    always_ff @(posedge clk) begin
        rd_data_o <= mem[rd_addr_i];
    end

endmodule

// ==== testbench/dcache_mem_model.sv ====
`timescale 1ns/10ps

module dcache_mem_model import dcache_pkg::*; #(
    parameter word_t FILL = 32'h5a3c96e1
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  rd_req_i,
    input  word_t rd_addr_i,
    output logic  ret_valid_o,
    output line_t ret_data_o,
    input  logic  wr_req_i,
    input  word_t wr_addr_i,
    input  line_t wr_data_i,
    input  logic  unc_ren_i,
    input  logic  unc_wen_i,
    input  word_t unc_addr_i,
    input  word_t unc_wdata_i,
    input  strb_t unc_strb_i,
    output logic  unc_rvalid_o,
    output word_t unc_rdata_o,
    output logic  unc_bvalid_o
);

    localparam int AW = 14;   // 64 KiB backing store

    word_t  mem [2**AW];
    integer seed;
    int     rd_wait, ur_wait, uw_wait;   // zero when nothing is pending
    word_t  rd_line_addr, ur_addr;

    // request records, read by the testbench
    int     rd_count, wr_count, unc_rd_count, unc_wr_count;
    word_t  last_wb_addr, last_unc_addr, last_unc_wdata;
    line_t  last_wb_data;
    strb_t  last_unc_strb;

    function automatic int latency();
        return 1 + ({$random(seed)} % 8);
    endfunction

    initial begin
        seed = 32'hf8c465c1;
        for (int i = 0; i < 2**AW; i++) begin
            mem[i] = word_t'(i << 2) ^ FILL;
        end
        ret_valid_o  = 1'b0;
        ret_data_o   = '0;
        unc_rvalid_o = 1'b0;
        unc_rdata_o  = '0;
        unc_bvalid_o = 1'b0;
        rd_wait      = 0;
        ur_wait      = 0;
        uw_wait      = 0;
        rd_count     = 0;
        wr_count     = 0;
        unc_rd_count = 0;
        unc_wr_count = 0;
    end

    // requests are taken at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (rd_req_i) begin
                rd_line_addr = rd_addr_i;
                rd_wait      = latency();
                rd_count++;
            end
            if (wr_req_i) begin
                for (int w = 0; w < LINE_WORDS; w++) begin
                    mem[wr_addr_i[AW+1:2] + w] = wr_data_i[w*32 +: 32];
                end
                last_wb_addr = wr_addr_i;
                last_wb_data = wr_data_i;
                wr_count++;
            end
            if (unc_ren_i) begin
                ur_addr       = unc_addr_i;
                last_unc_addr = unc_addr_i;
                ur_wait       = latency();
                unc_rd_count++;
            end
            if (unc_wen_i) begin
                for (int b = 0; b < 4; b++) begin
                    if (unc_strb_i[b]) mem[unc_addr_i[AW+1:2]][b*8 +: 8] = unc_wdata_i[b*8 +: 8];
                end
                last_unc_addr  = unc_addr_i;
                last_unc_wdata = unc_wdata_i;
                last_unc_strb  = unc_strb_i;
                uw_wait        = latency();
                unc_wr_count++;
            end
        end
    end

    // answers go out on the falling edge, one cycle wide
    always @(negedge clk) begin
        ret_valid_o  = 1'b0;
        unc_rvalid_o = 1'b0;
        unc_bvalid_o = 1'b0;
        if (rd_wait > 0) begin
            rd_wait--;
            if (rd_wait == 0) begin
                ret_valid_o = 1'b1;
                for (int w = 0; w < LINE_WORDS; w++) begin
                    ret_data_o[w*32 +: 32] = mem[rd_line_addr[AW+1:5] * LINE_WORDS + w];
                end
            end
        end
        if (ur_wait > 0) begin
            ur_wait--;
            if (ur_wait == 0) begin
                unc_rvalid_o = 1'b1;
                unc_rdata_o  = mem[ur_addr[AW+1:2]];
            end
        end
        if (uw_wait > 0) begin
            uw_wait--;
            if (uw_wait == 0) unc_bvalid_o = 1'b1;
        end
    end

endmodule

// ==== testbench/tb_dcache_top.sv ====
`timescale 1ns/10ps

module tb_dcache_top import dcache_pkg::*; ();

    localparam word_t FILL     = 32'h5a3c96e1;
    localparam int    MEM_AW   = 14;
    localparam int    NUM_REQS = 26;
    localparam word_t LINE_A   = 32'h0000_1040;   // A, B and C share set 2
    localparam word_t LINE_B   = 32'h0000_2040;
    localparam word_t LINE_C   = 32'h0000_3040;
    localparam word_t UNC_ADDR = 32'h0000_0300;

    logic    clk, reset;
    logic    req_i, uncached_i, ready_o, data_ok_o;
    mem_op_e op_i;
    word_t   addr_i, wdata_i, rdata_o;
    strb_t   wstrb_i, unc_strb_o;
    logic    rd_req_o, ret_valid_i, wr_req_o;
    word_t   rd_addr_o, wr_addr_o;
    line_t   ret_data_i, wr_data_o;
    logic    unc_ren_o, unc_wen_o, unc_rvalid_i, unc_bvalid_i;
    word_t   unc_addr_o, unc_wdata_o, unc_rdata_i;

    word_t   shadow [2**MEM_AW];   // expected memory contents
    int      errors, checks;

    dcache_top u_dcache_top (.*);

    dcache_mem_model #(.FILL(FILL)) u_mem (
        .clk          (clk),
        .reset        (reset),
        .rd_req_i     (rd_req_o),
        .rd_addr_i    (rd_addr_o),
        .ret_valid_o  (ret_valid_i),
        .ret_data_o   (ret_data_i),
        .wr_req_i     (wr_req_o),
        .wr_addr_i    (wr_addr_o),
        .wr_data_i    (wr_data_o),
        .unc_ren_i    (unc_ren_o),
        .unc_wen_i    (unc_wen_o),
        .unc_addr_i   (unc_addr_o),
        .unc_wdata_i  (unc_wdata_o),
        .unc_strb_i   (unc_strb_o),
        .unc_rvalid_o (unc_rvalid_i),
        .unc_rdata_o  (unc_rdata_i),
        .unc_bvalid_o (unc_bvalid_i)
    );

    always #10 clk = ~clk;

    function automatic word_t shadow_word(input word_t addr);
        return shadow[addr[MEM_AW+1:2]];
    endfunction

    function automatic line_t shadow_line(input word_t addr);
        line_t l;
        for (int w = 0; w < LINE_WORDS; w++) begin
            l[w*32 +: 32] = shadow[addr[MEM_AW+1:5] * LINE_WORDS + w];
        end
        return l;
    endfunction

    task automatic shadow_store(input word_t addr, input word_t data, input strb_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) shadow[addr[MEM_AW+1:2]][b*8 +: 8] = data[b*8 +: 8];
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_line(input string name, input line_t exp, input line_t act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED at time %0t: %s expected %h, actual %h", $time, name, exp, act);
        end
    endtask

    // one request, returns data and cycles from acceptance to data_ok_o
    task automatic access(input mem_op_e op, input logic unc, input word_t addr,
                          input word_t wdata, input strb_t strb,
                          output word_t rdata, output int cycles);
        @(negedge clk);
        req_i      = 1'b1;
        op_i       = op;
        uncached_i = unc;
        addr_i     = addr;
        wdata_i    = wdata;
        wstrb_i    = strb;
        @(posedge clk);
        while (!ready_o) @(posedge clk);
        @(negedge clk);
        req_i  = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!data_ok_o);
        rdata = rdata_o;
    endtask

    task automatic cached_op(input mem_op_e op, input word_t addr, input word_t wdata,
                             input strb_t strb, input int exp_rd, input int exp_wr);
        int    rd0, wr0, cycles;
        word_t rdata;
        rd0 = u_mem.rd_count;
        wr0 = u_mem.wr_count;
        if (op == OP_STORE) shadow_store(addr, wdata, strb);
        access(op, 1'b0, addr, wdata, strb, rdata, cycles);
        if (op == OP_LOAD) check_word("rdata_o", shadow_word(addr), rdata);
        check_word("rd_req_o pulses", exp_rd, u_mem.rd_count - rd0);
        check_word("wr_req_o pulses", exp_wr, u_mem.wr_count - wr0);
        if (exp_rd != 0) check_word("rd_addr_o", addr & 32'hffff_ffe0, u_mem.rd_line_addr);
        if (exp_rd == 0) check_word("data_ok_o latency", 1, cycles);   // hit
    endtask

    task automatic load(input word_t addr, input int exp_rd, input int exp_wr);
        cached_op(OP_LOAD, addr, '0, '0, exp_rd, exp_wr);
    endtask

    task automatic test_load_miss_hit();
        load(32'h0000_0104, 1, 0);
        load(32'h0000_0118, 0, 0);
    endtask

    task automatic test_store_hit_strobes();
        cached_op(OP_STORE, 32'h0000_0108, 32'haabbccdd, 4'b0001, 0, 0);
        cached_op(OP_STORE, 32'h0000_0108, 32'h11223344, 4'b0110, 0, 0);
        cached_op(OP_STORE, 32'h0000_010c, 32'hcafef00d, 4'b1111, 0, 0);
        load(32'h0000_0108, 0, 0);
        load(32'h0000_010c, 0, 0);
    endtask

    task automatic test_store_miss();
        cached_op(OP_STORE, 32'h0000_0204, 32'h8badf00d, 4'b1100, 1, 0);
        load(32'h0000_0204, 0, 0);
    endtask

    task automatic test_lru_writeback();
        cached_op(OP_STORE, LINE_A, 32'h0f0f0f0f, 4'b1111, 1, 0);
        load(LINE_A, 0, 0);
        load(LINE_B, 1, 0);
        load(LINE_A, 0, 0);
        load(LINE_C, 1, 0);   // clean B goes
        load(LINE_A, 0, 0);
        load(LINE_B, 1, 0);   // clean C goes
        cached_op(OP_STORE, LINE_B + 4, 32'h12345678, 4'b1111, 0, 0);
        load(LINE_A, 0, 0);
        load(LINE_C, 1, 1);   // dirty B written back
        check_word("wr_addr_o", LINE_B, u_mem.last_wb_addr);
        check_line("wr_data_o", shadow_line(LINE_B), u_mem.last_wb_data);
    endtask

    task automatic test_uncached();
        int    rd0, cycles;
        word_t rdata;
        rd0 = u_mem.rd_count;
        shadow_store(UNC_ADDR, 32'h76543210, 4'b1011);
        access(OP_STORE, 1'b1, UNC_ADDR, 32'h76543210, 4'b1011, rdata, cycles);
        check_word("unc_wen_o pulses", 1, u_mem.unc_wr_count);
        check_word("unc_addr_o", UNC_ADDR, u_mem.last_unc_addr);
        check_word("unc_wdata_o", 32'h76543210, u_mem.last_unc_wdata);
        check_word("unc_strb_o", 4'b1011, u_mem.last_unc_strb);
        access(OP_LOAD, 1'b1, UNC_ADDR, '0, '0, rdata, cycles);
        check_word("unc_ren_o pulses", 1, u_mem.unc_rd_count);
        check_word("unc_addr_o", UNC_ADDR, u_mem.last_unc_addr);
        check_word("rdata_o", shadow_word(UNC_ADDR), rdata);
        check_word("rd_req_o pulses", 0, u_mem.rd_count - rd0);
        load(UNC_ADDR, 1, 0);
    endtask

    // four loads to line 0x100 with req_i held high
    task automatic test_back_to_back();
        int accepted, got, cyc, ok_prev;
        accepted = 0;
        got      = 0;
        cyc      = 0;
        ok_prev  = 1;   // first acceptance edge
        @(negedge clk);
        req_i      = 1'b1;
        op_i       = OP_LOAD;
        uncached_i = 1'b0;
        addr_i     = 32'h0000_0100;
        while (got < 4) begin
            @(posedge clk);
            cyc++;
            if (req_i) begin
                check_word("ready_o", 1, ready_o);
                if (ready_o) accepted++;
            end
            if (data_ok_o) begin
                check_word("rdata_o", shadow_word(32'h0000_0100 + 4 * got), rdata_o);
                check_word("data_ok_o cycle", ok_prev + 1, cyc);
                ok_prev = cyc;
                got++;
            end
            @(negedge clk);
            if (accepted == 4) req_i = 1'b0;
            addr_i = 32'h0000_0100 + 4 * accepted;
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        for (int i = 0; i < 2**MEM_AW; i++) begin
            shadow[i] = word_t'(i << 2) ^ FILL;   // each word starts as its address xor FILL
        end
        clk        = 1'b0;
        reset      = 1'b1;
        req_i      = 1'b0;
        op_i       = OP_LOAD;
        uncached_i = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        wstrb_i    = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        test_load_miss_hit();
        test_store_hit_strobes();
        test_store_miss();
        test_lru_writeback();
        test_uncached();
        test_back_to_back();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // worst case per request plus margin for reset
    initial begin
        repeat (NUM_REQS * (8 + 4) + 1000) @(posedge clk);
        $display("timeout, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

endmodule
